//--- verilog/pic_pkg.sv
package pic_pkg;

    // eight request lines, fixed by the three level bits of the vector byte
    localparam int IRQ_LINES = 8;

    typedef logic [IRQ_LINES-1:0] irq_vec_t;
    typedef logic [2:0]           level_t;
    // T7-T3 of the vector byte
    typedef logic [4:0]           vector_base_t;

    // encoding 2'b11 unused
    typedef enum logic [1:0] {
        INIT_READY = 2'b00,
        INIT_ICW2  = 2'b01,
        INIT_ICW4  = 2'b10
    } init_state_e;

    typedef enum logic [1:0] {
        ACK_IDLE   = 2'b00,
        ACK_FIRST  = 2'b01,
        ACK_SECOND = 2'b10
    } ack_state_e;

    // OCW2 R / SL / EOI field, data bits 7-5
    typedef enum logic [2:0] {
        ROT_AEOI_CLEAR  = 3'b000,
        NONSPEC_EOI     = 3'b001,
        SPEC_EOI        = 3'b011,
        ROT_AEOI_SET    = 3'b100,
        ROT_NONSPEC_EOI = 3'b101,
        SET_PRIORITY    = 3'b110,
        ROT_SPEC_EOI    = 3'b111
    } ocw2_cmd_e;

    function automatic irq_vec_t level_to_one_hot(input level_t level);
        irq_vec_t v;
        v        = '0;
        v[level] = 1'b1;
        return v;
    endfunction

    // lowest set bit wins, 7 when empty
    function automatic level_t one_hot_to_level(input irq_vec_t v);
        level_t level;
        level = 3'd7;
        for (int i = IRQ_LINES - 1; i >= 0; i--) begin
            if (v[i])
                level = level_t'(i);
        end
        return level;
    endfunction

endpackage

//--- verilog/pic_if.sv
// write enables from the init FSM to the register block
interface reg_write_if;
    logic icw2_we;
    logic icw4_we;
    logic ocw1_we;
    logic ocw2_we;
    logic ocw3_we;

    modport seq (
        output icw2_we, icw4_we, ocw1_we, ocw2_we, ocw3_we
    );

    modport regs (
        input icw2_we, icw4_we, ocw1_we, ocw2_we, ocw3_we
    );
endinterface

// acknowledge FSM status, shared by registers and vector drive
interface ack_status_if;
    pic_pkg::ack_state_e ack_state;
    logic                latch_in_service;
    logic                end_of_ack;
    logic                vector_phase;

    modport seq (
        output ack_state, latch_in_service, end_of_ack, vector_phase
    );

    modport user (
        input ack_state, latch_in_service, end_of_ack, vector_phase
    );
endinterface

//--- verilog/init_sequencer.sv
module init_sequencer (
    input  logic write_initial_command_word_2_4,
    input  logic rst_n,
    input  logic icw1_write,
    input  logic icw_write,
    input  logic ocw1_write,
    input  logic ocw2_write,
    input  logic ocw3_write,
    input  logic ic4,
    reg_write_if.seq wr
);

    pic_pkg::init_state_e state;
    pic_pkg::init_state_e next_state;

    // ICW1 restarts the sequence from any state
    always_comb begin
        next_state = state;
        if (icw1_write) begin
            next_state = pic_pkg::INIT_ICW2;
        end else if (icw_write) begin
            case (state)
                pic_pkg::INIT_ICW2: begin
                    // no ICW3, single master only
                    if (ic4)
                        next_state = pic_pkg::INIT_ICW4;
                    else
                        next_state = pic_pkg::INIT_READY;
                end
                pic_pkg::INIT_ICW4: begin
                    next_state = pic_pkg::INIT_READY;
                end
                default: begin
                    next_state = state;
                end
            endcase
        end
    end

    always_ff @(posedge write_initial_command_word_2_4 or negedge rst_n) begin
        if (!rst_n)
            state <= pic_pkg::INIT_READY;
        else
            state <= next_state;
    end

    // ICW strobes only in their own state
    assign wr.icw2_we = icw_write && (state == pic_pkg::INIT_ICW2);
    assign wr.icw4_we = icw_write && (state == pic_pkg::INIT_ICW4);

    // OCWs ignored until init done
    assign wr.ocw1_we = ocw1_write && (state == pic_pkg::INIT_READY);
    assign wr.ocw2_we = ocw2_write && (state == pic_pkg::INIT_READY);
    assign wr.ocw3_we = ocw3_write && (state == pic_pkg::INIT_READY);

    // never lands in the spare encoding
    state_legal_a: assert property (
        @(posedge write_initial_command_word_2_4) disable iff (!rst_n)
        state != pic_pkg::init_state_e'(2'b11)
    );

endmodule

//--- verilog/ack_sequencer.sv
module ack_sequencer (
    input  logic write_initial_command_word_2_4,
    input  logic rst_n,
    input  logic icw1_write,
    input  logic ocw2_write,
    input  logic interrupt_acknowledge_n,
    output logic freeze,
    ack_status_if.seq ack
);

    pic_pkg::ack_state_e state;
    pic_pkg::ack_state_e next_state;
    logic                prev_ack_n;
    logic                ack_fall;
    logic                ack_rise;

    // INTA sampled once for edge detect
    always_ff @(posedge write_initial_command_word_2_4 or negedge rst_n) begin
        if (!rst_n)
            prev_ack_n <= 1'b1;
        else if (icw1_write)
            prev_ack_n <= 1'b1;
        else
            prev_ack_n <= interrupt_acknowledge_n;
    end

    assign ack_fall = prev_ack_n & ~interrupt_acknowledge_n;
    assign ack_rise = ~prev_ack_n & interrupt_acknowledge_n;

    always_comb begin
        next_state = state;
        case (state)
            pic_pkg::ACK_IDLE: begin
                // OCW2 in flight holds off a new sequence
                if (ack_fall && !ocw2_write)
                    next_state = pic_pkg::ACK_FIRST;
            end
            pic_pkg::ACK_FIRST: begin
                if (ack_rise)
                    next_state = pic_pkg::ACK_SECOND;
            end
            pic_pkg::ACK_SECOND: begin
                if (ack_rise)
                    next_state = pic_pkg::ACK_IDLE;
            end
            default: begin
                next_state = pic_pkg::ACK_IDLE;
            end
        endcase
        if (icw1_write)
            next_state = pic_pkg::ACK_IDLE;
    end

    always_ff @(posedge write_initial_command_word_2_4 or negedge rst_n) begin
        if (!rst_n)
            state <= pic_pkg::ACK_IDLE;
        else
            state <= next_state;
    end

    assign ack.ack_state = state;
    // first INTA falling edge
    assign ack.latch_in_service = (state == pic_pkg::ACK_IDLE) &&
                                  (next_state != pic_pkg::ACK_IDLE);
    assign ack.end_of_ack = (state == pic_pkg::ACK_SECOND) &&
                            (next_state == pic_pkg::ACK_IDLE);
    // vector byte window while second INTA is low
    assign ack.vector_phase = (state == pic_pkg::ACK_SECOND) && !interrupt_acknowledge_n;
    // IRR held while a sequence is running or about to start
    assign freeze = (next_state != pic_pkg::ACK_IDLE);

    lis_single_a: assert property (
        @(posedge write_initial_command_word_2_4) disable iff (!rst_n)
        ack.latch_in_service |=> !ack.latch_in_service
    );

    // normal end pulse comes right after the vector byte window
    end_from_second_a: assert property (
        @(posedge write_initial_command_word_2_4) disable iff (!rst_n)
        (ack.end_of_ack && !icw1_write) |-> $past(ack.vector_phase)
    );

endmodule

//--- verilog/command_registers.sv
module command_registers (
    input  logic                  write_initial_command_word_2_4,
    input  logic                  rst_n,
    input  logic                  icw1_write,
    input  pic_pkg::irq_vec_t     data_bus,
    input  pic_pkg::irq_vec_t     highest_level_in_service,
    input  pic_pkg::irq_vec_t     acknowledged,
    reg_write_if.regs             wr,
    ack_status_if.user            ack,
    output logic                  ic4,
    output pic_pkg::vector_base_t vector_base,
    output logic                  level_or_edge_triggered_config,
    output pic_pkg::irq_vec_t     interrupt_mask,
    output pic_pkg::level_t       priority_rotate,
    output pic_pkg::irq_vec_t     end_of_interrupt,
    output logic                  enable_read_register,
    output logic                  read_register_isr_or_irr
);

    logic                aeoi;
    logic                auto_rotate;
    pic_pkg::ocw2_cmd_e  cmd;
    logic                spec_eoi_cmd;

    assign cmd = pic_pkg::ocw2_cmd_e'(data_bus[7:5]);
    assign spec_eoi_cmd = wr.ocw2_we &&
                          (cmd == pic_pkg::SPEC_EOI || cmd == pic_pkg::ROT_SPEC_EOI);

    // ICW1 LTIM and IC4, ICW2 base, ICW4 AEOI
    always_ff @(posedge write_initial_command_word_2_4 or negedge rst_n) begin
        if (!rst_n) begin
            level_or_edge_triggered_config <= 1'b0;
            ic4                            <= 1'b0;
            vector_base                    <= '0;
            aeoi                           <= 1'b0;
        end else if (icw1_write) begin
            level_or_edge_triggered_config <= data_bus[3];
            ic4                            <= data_bus[0];
            vector_base                    <= '0;
            aeoi                           <= 1'b0;
        end else begin
            if (wr.icw2_we)
                vector_base <= data_bus[7:3];
            if (wr.icw4_we)
                aeoi <= data_bus[1];
        end
    end

    // OCW1 mask, all lines masked until written
    always_ff @(posedge write_initial_command_word_2_4 or negedge rst_n) begin
        if (!rst_n)
            interrupt_mask <= '1;
        else if (icw1_write)
            interrupt_mask <= '1;
        else if (wr.ocw1_we)
            interrupt_mask <= data_bus;
    end

    // rotation mode and lowest priority level
    always_ff @(posedge write_initial_command_word_2_4 or negedge rst_n) begin
        if (!rst_n) begin
            auto_rotate     <= 1'b0;
            priority_rotate <= 3'd7;
        end else if (icw1_write) begin
            auto_rotate     <= 1'b0;
            priority_rotate <= 3'd7;
        end else if (auto_rotate && ack.end_of_ack) begin
            // served line drops to lowest priority
            priority_rotate <= pic_pkg::one_hot_to_level(acknowledged);
        end else if (wr.ocw2_we) begin
            case (cmd)
                pic_pkg::ROT_AEOI_CLEAR:  auto_rotate <= 1'b0;
                pic_pkg::ROT_AEOI_SET:    auto_rotate <= 1'b1;
                pic_pkg::ROT_NONSPEC_EOI:
                    priority_rotate <= pic_pkg::one_hot_to_level(highest_level_in_service);
                pic_pkg::SET_PRIORITY,
                pic_pkg::ROT_SPEC_EOI:    priority_rotate <= data_bus[2:0];
                default: begin
                end
            endcase
        end
    end

    // OCW3 RR and RIS
    always_ff @(posedge write_initial_command_word_2_4 or negedge rst_n) begin
        if (!rst_n) begin
            enable_read_register     <= 1'b1;
            read_register_isr_or_irr <= 1'b0;
        end else if (icw1_write) begin
            enable_read_register     <= 1'b1;
            read_register_isr_or_irr <= 1'b0;
        end else if (wr.ocw3_we) begin
            enable_read_register     <= data_bus[1];
            read_register_isr_or_irr <= data_bus[0];
        end
    end

    // EOI vector, automatic EOI takes precedence
    always_comb begin
        end_of_interrupt = '0;
        if (aeoi && ack.end_of_ack) begin
            end_of_interrupt = acknowledged;
        end else if (wr.ocw2_we) begin
            case (cmd)
                pic_pkg::NONSPEC_EOI,
                pic_pkg::ROT_NONSPEC_EOI: end_of_interrupt = highest_level_in_service;
                pic_pkg::SPEC_EOI,
                pic_pkg::ROT_SPEC_EOI:
                    end_of_interrupt = pic_pkg::level_to_one_hot(data_bus[2:0]);
                default:                  end_of_interrupt = '0;
            endcase
        end
    end

    spec_eoi_one_hot_a: assert property (
        @(posedge write_initial_command_word_2_4) disable iff (!rst_n)
        (spec_eoi_cmd && !(aeoi && ack.end_of_ack)) |-> $onehot(end_of_interrupt)
    );

endmodule

//--- verilog/vector_output.sv
module vector_output (
    input  logic                  write_initial_command_word_2_4,
    input  logic                  rst_n,
    input  logic                  icw1_write,
    input  pic_pkg::irq_vec_t     interrupt,
    input  pic_pkg::vector_base_t vector_base,
    ack_status_if.user            ack,
    output pic_pkg::irq_vec_t     acknowledged,
    output pic_pkg::irq_vec_t     clear_interrupt_request,
    output logic                  interrupt_to_cpu,
    output logic                  vector_out_enable,
    output logic [7:0]            vector_data
);

    // line taken on first INTA, held through the sequence
    always_ff @(posedge write_initial_command_word_2_4 or negedge rst_n) begin
        if (!rst_n)
            acknowledged <= '0;
        else if (icw1_write)
            acknowledged <= '0;
        else if (ack.end_of_ack)
            acknowledged <= '0;
        else if (ack.latch_in_service)
            acknowledged <= interrupt;
    end

    // ICW1 wipes the whole request register
    always_comb begin
        if (icw1_write)
            clear_interrupt_request = '1;
        else if (ack.latch_in_service)
            clear_interrupt_request = interrupt;
        else
            clear_interrupt_request = '0;
    end

    // INT to CPU, a pending request keeps it set
    always_ff @(posedge write_initial_command_word_2_4 or negedge rst_n) begin
        if (!rst_n)
            interrupt_to_cpu <= 1'b0;
        else if (icw1_write)
            interrupt_to_cpu <= 1'b0;
        else if (interrupt != '0)
            interrupt_to_cpu <= 1'b1;
        else if (ack.end_of_ack)
            interrupt_to_cpu <= 1'b0;
    end

    // vector byte, T7-T3 then the line number
    assign vector_out_enable = ack.vector_phase;
    assign vector_data = ack.vector_phase ?
                         {vector_base, pic_pkg::one_hot_to_level(acknowledged)} : 8'h00;

    vector_in_second_a: assert property (
        @(posedge write_initial_command_word_2_4) disable iff (!rst_n)
        vector_out_enable |-> ack.ack_state == pic_pkg::ACK_SECOND
    );

endmodule

//--- verilog/pic_control.sv
module pic_control (
    input  logic                 write_initial_command_word_2_4,
    input  logic                 rst_n,
    input  logic                 icw1_write,
    input  logic                 icw_write,
    input  logic                 ocw1_write,
    input  logic                 ocw2_write,
    input  logic                 ocw3_write,
    input  pic_pkg::irq_vec_t    data_bus,
    input  pic_pkg::irq_vec_t    interrupt,
    input  pic_pkg::irq_vec_t    highest_level_in_service,
    input  logic                 interrupt_acknowledge_n,
    output logic                 level_or_edge_triggered_config,
    output pic_pkg::irq_vec_t    interrupt_mask,
    output pic_pkg::level_t      priority_rotate,
    output pic_pkg::irq_vec_t    end_of_interrupt,
    output logic                 enable_read_register,
    output logic                 read_register_isr_or_irr,
    output logic                 interrupt_to_cpu,
    output logic                 freeze,
    output logic                 latch_in_service,
    output pic_pkg::irq_vec_t    clear_interrupt_request,
    output pic_pkg::irq_vec_t    acknowledge_interrupt,
    output logic                 vector_out_enable,
    output logic [7:0]           vector_data
);

    // IC4 back to the init FSM
    logic                  ic4;
    pic_pkg::vector_base_t vector_base;

    reg_write_if  wr ();
    ack_status_if ack ();

    // pulse also leaves the chip
    assign latch_in_service = ack.latch_in_service;

    init_sequencer init_sequencer_i (
        .write_initial_command_word_2_4 (write_initial_command_word_2_4),
        .rst_n                          (rst_n),
        .icw1_write                     (icw1_write),
        .icw_write                      (icw_write),
        .ocw1_write                     (ocw1_write),
        .ocw2_write                     (ocw2_write),
        .ocw3_write                     (ocw3_write),
        .ic4                            (ic4),
        .wr                             (wr.seq)
    );

    ack_sequencer ack_sequencer_i (
        .write_initial_command_word_2_4 (write_initial_command_word_2_4),
        .rst_n                          (rst_n),
        .icw1_write                     (icw1_write),
        .ocw2_write                     (ocw2_write),
        .interrupt_acknowledge_n        (interrupt_acknowledge_n),
        .freeze                         (freeze),
        .ack                            (ack.seq)
    );

    command_registers command_registers_i (
        .write_initial_command_word_2_4 (write_initial_command_word_2_4),
        .rst_n                          (rst_n),
        .icw1_write                     (icw1_write),
        .data_bus                       (data_bus),
        .highest_level_in_service       (highest_level_in_service),
        .acknowledged                   (acknowledge_interrupt),
        .wr                             (wr.regs),
        .ack                            (ack.user),
        .ic4                            (ic4),
        .vector_base                    (vector_base),
        .level_or_edge_triggered_config (level_or_edge_triggered_config),
        .interrupt_mask                 (interrupt_mask),
        .priority_rotate                (priority_rotate),
        .end_of_interrupt               (end_of_interrupt),
        .enable_read_register           (enable_read_register),
        .read_register_isr_or_irr       (read_register_isr_or_irr)
    );

    vector_output vector_output_i (
        .write_initial_command_word_2_4 (write_initial_command_word_2_4),
        .rst_n                          (rst_n),
        .icw1_write                     (icw1_write),
        .interrupt                      (interrupt),
        .vector_base                    (vector_base),
        .ack                            (ack.user),
        .acknowledged                   (acknowledge_interrupt),
        .clear_interrupt_request        (clear_interrupt_request),
        .interrupt_to_cpu               (interrupt_to_cpu),
        .vector_out_enable              (vector_out_enable),
        .vector_data                    (vector_data)
    );

endmodule

//--- tb/clock_gen.sv
// testbench clock and power-on reset
module clock_gen (
    output logic write_initial_command_word_2_4,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // 40 ns period
    localparam int RESET_CYCLES = 5;

    initial begin
        write_initial_command_word_2_4 = 1'b0;
        forever #20 write_initial_command_word_2_4 = ~write_initial_command_word_2_4;
    end

    // release mid-cycle, away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge write_initial_command_word_2_4);
        @(negedge write_initial_command_word_2_4);
        rst_n = 1'b1;
    end

endmodule

//--- tb/pic_tb.sv
module pic_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // cycles any wait loop may spend
    localparam int WAIT_LIMIT = 50;

    typedef enum logic [2:0] {
        OP_ICW1,
        OP_ICW,
        OP_OCW1,
        OP_OCW2,
        OP_OCW3,
        OP_ACK
    } op_e;

    // irq drives interrupt for OP_ACK, highest_level_in_service for OP_OCW2
    typedef struct packed {
        op_e        op;
        logic [7:0] data;
        logic [7:0] irq;
        logic [7:0] exp_eoi;
        logic [7:0] exp_vector;
        logic       exp_ltim;
        logic [7:0] exp_mask;
        logic [2:0] exp_prio;
        logic       exp_rr;
        logic       exp_ris;
    } step_t;

    logic       write_initial_command_word_2_4;
    logic       rst_n;
    logic       icw1_write;
    logic       icw_write;
    logic       ocw1_write;
    logic       ocw2_write;
    logic       ocw3_write;
    logic [7:0] data_bus;
    logic [7:0] interrupt;
    logic [7:0] highest_level_in_service;
    logic       interrupt_acknowledge_n;
    logic       level_or_edge_triggered_config;
    logic [7:0] interrupt_mask;
    logic [2:0] priority_rotate;
    logic [7:0] end_of_interrupt;
    logic       enable_read_register;
    logic       read_register_isr_or_irr;
    logic       interrupt_to_cpu;
    logic       freeze;
    logic       latch_in_service;
    logic [7:0] clear_interrupt_request;
    logic [7:0] acknowledge_interrupt;
    logic       vector_out_enable;
    logic [7:0] vector_data;

    step_t       table_q[$];
    string       names_q[$];
    logic [31:0] lcg_state;

    // register state expected after each row
    logic       e_ltim;
    logic [7:0] e_mask;
    logic [2:0] e_prio;
    logic       e_rr;
    logic       e_ris;
    logic [4:0] e_base;

    clock_gen clock_gen_i (
        .write_initial_command_word_2_4 (write_initial_command_word_2_4),
        .rst_n                          (rst_n)
    );

    pic_control dut_i (
        .write_initial_command_word_2_4 (write_initial_command_word_2_4),
        .rst_n                          (rst_n),
        .icw1_write                     (icw1_write),
        .icw_write                      (icw_write),
        .ocw1_write                     (ocw1_write),
        .ocw2_write                     (ocw2_write),
        .ocw3_write                     (ocw3_write),
        .data_bus                       (data_bus),
        .interrupt                      (interrupt),
        .highest_level_in_service       (highest_level_in_service),
        .interrupt_acknowledge_n        (interrupt_acknowledge_n),
        .level_or_edge_triggered_config (level_or_edge_triggered_config),
        .interrupt_mask                 (interrupt_mask),
        .priority_rotate                (priority_rotate),
        .end_of_interrupt               (end_of_interrupt),
        .enable_read_register           (enable_read_register),
        .read_register_isr_or_irr       (read_register_isr_or_irr),
        .interrupt_to_cpu               (interrupt_to_cpu),
        .freeze                         (freeze),
        .latch_in_service               (latch_in_service),
        .clear_interrupt_request        (clear_interrupt_request),
        .acknowledge_interrupt          (acknowledge_interrupt),
        .vector_out_enable              (vector_out_enable),
        .vector_data                    (vector_data)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // lowest numbered line that is set, 7 for none
    function automatic logic [2:0] lowest_set_level(input logic [7:0] v);
        logic [2:0] level;
        logic       found;
        level = 3'd7;
        found = 1'b0;
        for (int i = 0; i < 8; i++) begin
            if (v[i] && !found) begin
                level = 3'(i);
                found = 1'b1;
            end
        end
        return level;
    endfunction

    task automatic next_random(output logic [31:0] r);
        lcg_state = lcg_next(lcg_state);
        r = lcg_state;
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [7:0] expected,
                         input logic [7:0] actual);
        if (expected !== actual)
            fail_run($sformatf("FAILED %s expected %02h actual %02h", name, expected, actual));
    endtask

    // inputs change 2 ns after the edge
    task automatic step_drive();
        @(posedge write_initial_command_word_2_4);
        #2;
    endtask

    // mid-cycle sample point
    task automatic settle();
        #18;
    endtask

    task automatic clear_strobes();
        icw1_write = 1'b0;
        icw_write  = 1'b0;
        ocw1_write = 1'b0;
        ocw2_write = 1'b0;
        ocw3_write = 1'b0;
    endtask

    task automatic add_step(input string name, input op_e op, input logic [7:0] data,
                            input logic [7:0] irq, input logic [7:0] eoi,
                            input logic [7:0] vec);
        step_t s;
        s.op         = op;
        s.data       = data;
        s.irq        = irq;
        s.exp_eoi    = eoi;
        s.exp_vector = vec;
        s.exp_ltim   = e_ltim;
        s.exp_mask   = e_mask;
        s.exp_prio   = e_prio;
        s.exp_rr     = e_rr;
        s.exp_ris    = e_ris;
        table_q.push_back(s);
        names_q.push_back(name);
    endtask

    // ICW1 puts every register back to its reset value
    task automatic expect_icw1(input logic ltim);
        e_ltim = ltim;
        e_mask = 8'hFF;
        e_prio = 3'd7;
        e_rr   = 1'b1;
        e_ris  = 1'b0;
        e_base = 5'd0;
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [2:0]  n;
        logic [7:0]  v;

        // level mode, no ICW4
        expect_icw1(1'b1);
        add_step("icw1 ltim", OP_ICW1, 8'h18, 8'h00, 8'h00, 8'h00);
        next_random(r);
        e_base = r[12:8];
        add_step("icw2 base", OP_ICW, {e_base, 3'b000}, 8'h00, 8'h00, 8'h00);
        next_random(r);
        e_mask = r[15:8];
        add_step("ocw1 mask", OP_OCW1, e_mask, 8'h00, 8'h00, 8'h00);

        // plain acknowledge, no EOI at the end
        next_random(r);
        n = r[18:16];
        add_step("ack line", OP_ACK, 8'h00, 8'h01 << n, 8'h00, {e_base, n});

        // EOI commands
        next_random(r);
        n = r[18:16];
        add_step("ocw2 specific eoi", OP_OCW2, {3'b011, 2'b00, n}, 8'h00,
                 8'h01 << n, 8'h00);
        next_random(r);
        v = 8'h01 << r[18:16];
        add_step("ocw2 nonspecific eoi", OP_OCW2, 8'h20, v, v, 8'h00);
        next_random(r);
        v = r[15:8] | 8'h01;
        add_step("ocw2 rotate aeoi clear", OP_OCW2, {3'b000, r[4:0]}, v, 8'h00, 8'h00);

        // rotation
        next_random(r);
        n = r[18:16];
        e_prio = n;
        add_step("ocw2 set priority", OP_OCW2, {3'b110, 2'b00, n}, 8'h00, 8'h00, 8'h00);
        next_random(r);
        v = r[15:8] | 8'h80;
        e_prio = lowest_set_level(v);
        add_step("ocw2 rotate nonspecific eoi", OP_OCW2, 8'hA0, v, v, 8'h00);

        // all RR / RIS pairs
        for (int k = 0; k < 4; k++) begin
            e_rr  = k[1];
            e_ris = k[0];
            add_step($sformatf("ocw3 rr %0d ris %0d", e_rr, e_ris), OP_OCW3,
                     {6'b000010, e_rr, e_ris}, 8'h00, 8'h00, 8'h00);
        end

        // second init, with ICW4 and automatic EOI
        expect_icw1(1'b0);
        add_step("icw1 ic4", OP_ICW1, 8'h11, 8'h00, 8'h00, 8'h00);
        next_random(r);
        e_base = r[12:8];
        add_step("icw2 base aeoi", OP_ICW, {e_base, 3'b000}, 8'h00, 8'h00, 8'h00);
        add_step("icw4 aeoi", OP_ICW, 8'h03, 8'h00, 8'h00, 8'h00);
        add_step("ocw2 rotate aeoi set", OP_OCW2, 8'h80, 8'h00, 8'h00, 8'h00);

        // line kept below 4 so the rotation visibly moves off 7
        next_random(r);
        n = {1'b0, r[17:16]};
        e_prio = n;
        add_step("ack aeoi rotate", OP_ACK, 8'h00, 8'h01 << n, 8'h01 << n, {e_base, n});
    endtask

    task automatic check_registers(input int idx);
        step_t s;
        string nm;
        s  = table_q[idx];
        nm = names_q[idx];
        check({nm, " ltim"}, 8'(s.exp_ltim), 8'(level_or_edge_triggered_config));
        check({nm, " interrupt_mask"}, s.exp_mask, interrupt_mask);
        check({nm, " priority_rotate"}, 8'(s.exp_prio), 8'(priority_rotate));
        check({nm, " enable_read_register"}, 8'(s.exp_rr), 8'(enable_read_register));
        check({nm, " read_register_isr_or_irr"}, 8'(s.exp_ris),
              8'(read_register_isr_or_irr));
    endtask

    // one strobe cycle, then one cycle for the registered result
    task automatic apply_write(input int idx);
        step_t s;
        string nm;
        s  = table_q[idx];
        nm = names_q[idx];
        step_drive();
        data_bus = s.data;
        case (s.op)
            OP_ICW1: icw1_write = 1'b1;
            OP_ICW:  icw_write  = 1'b1;
            OP_OCW1: ocw1_write = 1'b1;
            OP_OCW2: begin
                ocw2_write               = 1'b1;
                highest_level_in_service = s.irq;
            end
            OP_OCW3: ocw3_write = 1'b1;
            default: begin
            end
        endcase
        settle();
        if (s.op == OP_ICW1)
            check({nm, " clear_interrupt_request"}, 8'hFF, clear_interrupt_request);
        // EOI only in the strobe cycle
        check({nm, " end_of_interrupt"}, s.exp_eoi, end_of_interrupt);
        step_drive();
        clear_strobes();
        highest_level_in_service = 8'h00;
        settle();
        check({nm, " end_of_interrupt idle"}, 8'h00, end_of_interrupt);
    endtask

    task automatic run_ack(input int idx);
        step_t s;
        string nm;
        int    cycles;
        s  = table_q[idx];
        nm = names_q[idx];

        step_drive();
        interrupt = s.irq;
        settle();
        cycles = 0;
        while (!interrupt_to_cpu && cycles < WAIT_LIMIT) begin
            step_drive();
            settle();
            cycles++;
        end
        if (!interrupt_to_cpu)
            fail_run({"interrupt_to_cpu never rose in ", nm});

        // first INTA low
        step_drive();
        interrupt_acknowledge_n = 1'b0;
        settle();
        check({nm, " latch_in_service"}, 8'h01, 8'(latch_in_service));
        check({nm, " freeze first"}, 8'h01, 8'(freeze));
        check({nm, " clear_interrupt_request"}, s.irq, clear_interrupt_request);

        // request drops before the sequence ends
        step_drive();
        interrupt_acknowledge_n = 1'b1;
        interrupt               = 8'h00;
        settle();
        check({nm, " latch pulse width"}, 8'h00, 8'(latch_in_service));
        check({nm, " acknowledge_interrupt"}, s.irq, acknowledge_interrupt);
        check({nm, " no early vector"}, 8'h00, 8'(vector_out_enable));

        // second INTA low, vector byte window
        step_drive();
        interrupt_acknowledge_n = 1'b0;
        settle();
        cycles = 0;
        while (!vector_out_enable && cycles < WAIT_LIMIT) begin
            step_drive();
            settle();
            cycles++;
        end
        if (!vector_out_enable)
            fail_run({"vector byte never driven in ", nm});
        check({nm, " vector_data"}, s.exp_vector, vector_data);
        check({nm, " acknowledge_interrupt held"}, s.irq, acknowledge_interrupt);

        // end cycle, automatic EOI shows here
        step_drive();
        interrupt_acknowledge_n = 1'b1;
        settle();
        check({nm, " end_of_interrupt end"}, s.exp_eoi, end_of_interrupt);
        check({nm, " vector released"}, 8'h00, 8'(vector_out_enable));
        check({nm, " freeze end"}, 8'h00, 8'(freeze));

        step_drive();
        settle();
        check({nm, " freeze after"}, 8'h00, 8'(freeze));
        check({nm, " interrupt_to_cpu after"}, 8'h00, 8'(interrupt_to_cpu));
        check({nm, " acknowledge cleared"}, 8'h00, acknowledge_interrupt);
    endtask

    initial begin
        int cycles;
        clear_strobes();
        data_bus                 = 8'h00;
        interrupt                = 8'h00;
        highest_level_in_service = 8'h00;
        interrupt_acknowledge_n  = 1'b1;
        lcg_state                = 32'h307b;
        build_table();

        cycles = 0;
        while (rst_n !== 1'b1 && cycles < WAIT_LIMIT) begin
            step_drive();
            cycles++;
        end
        if (rst_n !== 1'b1)
            fail_run("reset was never released");
        settle();

        // reset values
        check("reset interrupt_mask", 8'hFF, interrupt_mask);
        check("reset priority_rotate", 8'h07, 8'(priority_rotate));
        check("reset enable_read_register", 8'h01, 8'(enable_read_register));
        check("reset read_register_isr_or_irr", 8'h00, 8'(read_register_isr_or_irr));
        check("reset interrupt_to_cpu", 8'h00, 8'(interrupt_to_cpu));
        check("reset vector_out_enable", 8'h00, 8'(vector_out_enable));

        for (int i = 0; i < table_q.size(); i++) begin
            if (table_q[i].op == OP_ACK)
                run_ack(i);
            else
                apply_write(i);
            check_registers(i);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- src.f
verilog/pic_pkg.sv
verilog/pic_if.sv
verilog/init_sequencer.sv
verilog/ack_sequencer.sv
verilog/command_registers.sv
verilog/vector_output.sv
verilog/pic_control.sv
tb/clock_gen.sv
tb/pic_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pic_tb -f src.f -o Vpic_tb

./obj_dir/Vpic_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
